//--- pfd_calib_settings.svh
// build-time sizes for the PFD offset calibration core, included by packages and RTL
`ifndef PFD_CALIB_SETTINGS_SVH
`define PFD_CALIB_SETTINGS_SVH

//////////////////////////////////////////////////
// datapath widths
//////////////////////////////////////////////////

// adc sample width, two's complement
`define PFD_CALIB_NADC 8

// range width for bin width and dead zone
// bin counters are 2**NRANGE bits wide
`define PFD_CALIB_NRANGE 4

//////////////////////////////////////////////////
// window and link sizing
//////////////////////////////////////////////////

// samples per window is 2**WIN_LOG2
`define PFD_CALIB_WIN_LOG2 6

// input fifo depth, also the sender's starting credit
`define PFD_CALIB_BUF_DEPTH 4

// report credits held by the estimator after reset
`define PFD_CALIB_REPORT_CREDITS 2

//////////////////////////////////////////////////
// estimator limits
//////////////////////////////////////////////////

// offset saturates at plus or minus this magnitude
`define PFD_CALIB_OFFSET_MAX 31

`endif

//--- pfd_calib_data_pkg.sv
// sample, bin-count and offset types shared by the calibration datapath blocks
`default_nettype none

`include "pfd_calib_settings.svh"

package pfd_calib_data_pkg;

    //////////////////////////////////////////////////
    // samples
    //////////////////////////////////////////////////

    // one signed adc word
    typedef logic signed [`PFD_CALIB_NADC-1:0] sample_t;

    //////////////////////////////////////////////////
    // histogram
    //////////////////////////////////////////////////

    // bin count, wide enough for a full window
    typedef logic [(2**`PFD_CALIB_NRANGE)-1:0] hist_cnt_t;

    //////////////////////////////////////////////////
    // offset estimate
    //////////////////////////////////////////////////

    // magnitude bits plus sign
    localparam int OFFSET_W = $clog2(`PFD_CALIB_OFFSET_MAX + 1) + 1;

    // signed estimate, holds -OFFSET_MAX .. +OFFSET_MAX
    typedef logic signed [OFFSET_W-1:0] offset_t;

endpackage

`default_nettype wire

//--- pfd_calib_ctrl_pkg.sv
// vote encoding and configuration field types for the estimator and report link
`default_nettype none

`include "pfd_calib_settings.svh"

package pfd_calib_ctrl_pkg;

    //////////////////////////////////////////////////
    // vote
    //////////////////////////////////////////////////

    // two-bit signed step for the offset estimate
    typedef logic signed [1:0] vote_t;

    // move the offset down, center bin dominates
    localparam vote_t VOTE_DOWN = 2'sb11;
    // hold, counts inside the dead zone
    localparam vote_t VOTE_HOLD = 2'sb00;
    // move the offset up, sides dominate or bins empty
    localparam vote_t VOTE_UP = 2'sb01;
    // -2, never produced by the histogram
    localparam vote_t VOTE_UNUSED = 2'sb10;

    //////////////////////////////////////////////////
    // configuration fields
    //////////////////////////////////////////////////

    // bin width and dead zone exponent
    typedef logic [`PFD_CALIB_NRANGE-1:0] cfg_range_t;

endpackage

`default_nettype wire

//--- calib_sample_buffer.sv
// credit-returning input FIFO that parks ADC samples until the calibration core pops them
`timescale 1ns/100ps
`default_nettype none

`include "pfd_calib_settings.svh"

module calib_sample_buffer (
    input wire logic clk,
    input wire logic rstb,
    input wire logic sample_valid,
    input wire pfd_calib_data_pkg::sample_t sample_data,
    input wire logic take,
    output logic sample_credit,
    output logic buf_valid,
    output pfd_calib_data_pkg::sample_t buf_data
);

    localparam int DEPTH = `PFD_CALIB_BUF_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    //////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////

    pfd_calib_data_pkg::sample_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // sender only writes while holding a credit
    always_ff @(posedge clk) begin
        if (sample_valid) begin
            mem[wr_ptr] <= sample_data;
        end
    end

    //////////////////////////////////////////////////
    // pointers and occupancy
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (sample_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (take) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // push and pop together leave count alone
            case ({sample_valid, take})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // head of queue, visible the cycle after its write
    assign buf_valid = (count != '0);
    assign buf_data = mem[rd_ptr];

    //////////////////////////////////////////////////
    // credit return
    //////////////////////////////////////////////////

    // one pulse per freed entry, a cycle after the pop
    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            sample_credit <= 1'b0;
        end else begin
            sample_credit <= take;
        end
    end

endmodule

`default_nettype wire

//--- calib_avg_track.sv
// window averager that publishes the mean of each sample window at its last sample
`timescale 1ns/100ps
`default_nettype none

module calib_avg_track #(
    parameter integer Nadc = 8,
    parameter integer win_log2 = 6
) (
    input wire logic clk,
    input wire logic rstb,
    input wire logic take,
    input wire logic window_end,
    input wire logic signed [Nadc-1:0] din,
    output logic signed [Nadc-1:0] din_avg
);

    // accumulator holds a full window without overflow
    localparam integer Nacc = Nadc + win_log2;

    //////////////////////////////////////////////////
    // running sum
    //////////////////////////////////////////////////

    logic signed [Nacc-1:0] acc;
    logic signed [Nacc-1:0] din_ext;
    logic signed [Nacc-1:0] acc_sum;
    logic signed [Nacc-1:0] acc_shift;

    // sign extend the incoming sample
    assign din_ext = {{win_log2{din[Nadc-1]}}, din};

    // sum including the current sample
    assign acc_sum = acc + din_ext;

    // divide by window length, rounds toward minus infinity
    assign acc_shift = acc_sum >>> win_log2;

    //////////////////////////////////////////////////
    // accumulate and publish
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            acc <= '0;
            // average is zero before the first window closes
            din_avg <= '0;
        end else if (take) begin
            if (window_end) begin
                // last sample closes the window
                din_avg <= acc_shift[Nadc-1:0];
                acc <= '0;
            end else begin
                acc <= acc_sum;
            end
        end
    end

endmodule

`default_nettype wire

//--- calib_hist_measure.sv
// three-bin histogram around the window average with a dead-zone vote for the estimator
`timescale 1ns/100ps
`default_nettype none

module calib_hist_measure #(
    parameter integer Nadc = 8,
    parameter integer Nrange = 4
) (
    input wire logic clk,
    input wire logic rstb,
    input wire logic take,
    input wire logic update,
    input wire logic signed [Nadc-1:0] din,
    input wire logic signed [Nadc-1:0] din_avg,
    input wire logic [Nrange-1:0] Nbin,
    input wire logic [Nrange-1:0] DZ,
    output logic [(2**Nrange)-1:0] hist_center,
    output logic [(2**Nrange)-1:0] hist_side,
    output pfd_calib_ctrl_pkg::vote_t hist_comp_out
);

    // threshold math wide enough for avg +- (3*Nbin+2)
    localparam integer Nth = Nadc + Nrange;
    localparam integer Ncnt = 2**Nrange;

    //////////////////////////////////////////////////
    // thresholds
    //////////////////////////////////////////////////

    logic signed [Nth-1:0] avg_ext;
    logic signed [Nth-1:0] din_ext;
    logic signed [Nth-1:0] bin_ext;
    logic signed [Nth-1:0] th_l2;
    logic signed [Nth-1:0] th_l1;
    logic signed [Nth-1:0] th_r1;
    logic signed [Nth-1:0] th_r2;

    assign avg_ext = {{(Nth-Nadc){din_avg[Nadc-1]}}, din_avg};
    assign din_ext = {{(Nth-Nadc){din[Nadc-1]}}, din};
    // bin width is unsigned
    assign bin_ext = {{(Nth-Nrange){1'b0}}, Nbin};

    // inner edges at avg +- (Nbin+1)
    assign th_l1 = avg_ext - bin_ext - 1;
    assign th_r1 = avg_ext + bin_ext + 1;
    // outer edges at avg +- (3*Nbin+2)
    assign th_l2 = avg_ext - (bin_ext * 3) - 2;
    assign th_r2 = avg_ext + (bin_ext * 3) + 2;

    //////////////////////////////////////////////////
    // bin flags
    //////////////////////////////////////////////////

    logic is_left;
    logic is_center;
    logic is_right;

    // center is avg +- Nbin, each side 2*Nbin+1 wide
    assign is_left = (th_l2 < din_ext) && (din_ext <= th_l1);
    assign is_center = (th_l1 < din_ext) && (din_ext < th_r1);
    assign is_right = (th_r1 <= din_ext) && (din_ext < th_r2);

    //////////////////////////////////////////////////
    // bin counters
    //////////////////////////////////////////////////

    logic [Ncnt-1:0] cnt_left;
    logic [Ncnt-1:0] cnt_center;
    logic [Ncnt-1:0] cnt_right;

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            cnt_left <= '0;
            cnt_center <= '0;
            cnt_right <= '0;
        end else if (update) begin
            // restart from the closing sample's own flags
            cnt_left <= Ncnt'(is_left);
            cnt_center <= Ncnt'(is_center);
            cnt_right <= Ncnt'(is_right);
        end else if (take) begin
            cnt_left <= cnt_left + Ncnt'(is_left);
            cnt_center <= cnt_center + Ncnt'(is_center);
            cnt_right <= cnt_right + Ncnt'(is_right);
        end
    end

    //////////////////////////////////////////////////
    // center vs side
    //////////////////////////////////////////////////

    logic [Ncnt:0] side_sum;
    logic signed [Ncnt:0] hist_diff;
    logic signed [Ncnt:0] dz_hi;
    logic signed [Ncnt:0] dz_lo;

    // side result is the mean of both side bins
    assign side_sum = {1'b0, cnt_left} + {1'b0, cnt_right};
    assign hist_side = side_sum[Ncnt:1];
    assign hist_center = cnt_center;

    assign hist_diff = $signed({1'b0, hist_center}) - $signed({1'b0, hist_side});

    // dead zone is +- 2**DZ
    assign dz_hi = {{Ncnt{1'b0}}, 1'b1} << DZ;
    assign dz_lo = -dz_hi;

    //////////////////////////////////////////////////
    // vote
    //////////////////////////////////////////////////

    always_comb begin
        if ((hist_center == '0) && (hist_side == '0)) begin
            // nothing near the average, offset too small
            hist_comp_out = pfd_calib_ctrl_pkg::VOTE_UP;
        end else if (hist_diff > dz_hi) begin
            // center heavy
            hist_comp_out = pfd_calib_ctrl_pkg::VOTE_DOWN;
        end else if (hist_diff < dz_lo) begin
            // side heavy
            hist_comp_out = pfd_calib_ctrl_pkg::VOTE_UP;
        end else begin
            hist_comp_out = pfd_calib_ctrl_pkg::VOTE_HOLD;
        end
    end

endmodule

`default_nettype wire

//--- pfd_offset_est.sv
// window framing, saturating offset estimate and credit-gated report issue
`timescale 1ns/100ps
`default_nettype none

`include "pfd_calib_settings.svh"

module pfd_offset_est (
    input wire logic clk,
    input wire logic rstb,
    input wire logic buf_valid,
    input wire logic report_credit,
    input wire pfd_calib_ctrl_pkg::vote_t hist_comp_out,
    input wire pfd_calib_data_pkg::hist_cnt_t hist_center,
    input wire pfd_calib_data_pkg::hist_cnt_t hist_side,
    output logic take,
    output logic window_end,
    output logic report_valid,
    output pfd_calib_data_pkg::offset_t report_offset,
    output pfd_calib_ctrl_pkg::vote_t report_vote,
    output pfd_calib_data_pkg::hist_cnt_t report_center,
    output pfd_calib_data_pkg::hist_cnt_t report_side
);

    localparam int WIN_W = `PFD_CALIB_WIN_LOG2;
    localparam int CRED = `PFD_CALIB_REPORT_CREDITS;
    localparam int CRED_W = $clog2(CRED + 1);
    localparam int OFF_W = pfd_calib_data_pkg::OFFSET_W;

    //////////////////////////////////////////////////
    // framing and flow control
    //////////////////////////////////////////////////

    logic [WIN_W-1:0] win_cnt;
    logic [CRED_W-1:0] cred_cnt;
    logic win_last;

    assign win_last = &win_cnt;
    // stall only on a window end without a report credit
    assign take = buf_valid && (!win_last || (cred_cnt != '0));
    assign window_end = take && win_last;

    // credit is spent at the window-end take
    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            win_cnt <= '0;
            cred_cnt <= CRED_W'(CRED);
        end else begin
            if (take) begin
                win_cnt <= win_cnt + 1'b1;
            end
            case ({window_end, report_credit})
                2'b10: cred_cnt <= cred_cnt - 1'b1;
                2'b01: cred_cnt <= cred_cnt + 1'b1;
                default: cred_cnt <= cred_cnt;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // offset step and report
    //////////////////////////////////////////////////

    localparam logic signed [OFF_W:0] OFF_HI = `PFD_CALIB_OFFSET_MAX;
    localparam logic signed [OFF_W:0] OFF_LO = -`PFD_CALIB_OFFSET_MAX;

    logic signed [OFF_W:0] offset_sum;

    // one extra bit so the step cannot wrap
    assign offset_sum = report_offset + hist_comp_out;

    // report_offset doubles as the estimate register
    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            report_valid <= 1'b0;
            report_offset <= '0;
            report_vote <= pfd_calib_ctrl_pkg::VOTE_HOLD;
        end else begin
            report_valid <= window_end;
            if (window_end) begin
                if (offset_sum > OFF_HI) begin
                    report_offset <= OFF_HI[OFF_W-1:0];
                end else if (offset_sum < OFF_LO) begin
                    report_offset <= OFF_LO[OFF_W-1:0];
                end else begin
                    report_offset <= offset_sum[OFF_W-1:0];
                end
                report_vote <= hist_comp_out;
            end
        end
    end

    // count snapshot from before the restart
    always_ff @(posedge clk) begin
        if (window_end) begin
            report_center <= hist_center;
            report_side <= hist_side;
        end
    end

endmodule

`default_nettype wire

//--- pfd_calib_top.sv
// top level of the PFD offset calibration core, joins buffer, averager, histogram and estimator
`timescale 1ns/100ps
`default_nettype none

`include "pfd_calib_settings.svh"

module pfd_calib_top (
    input wire logic clk,
    input wire logic rstb,
    input wire logic sample_valid,
    input wire pfd_calib_data_pkg::sample_t sample_data,
    input wire pfd_calib_ctrl_pkg::cfg_range_t nbin,
    input wire pfd_calib_ctrl_pkg::cfg_range_t dz,
    input wire logic report_credit,
    output logic sample_credit,
    output logic report_valid,
    output pfd_calib_data_pkg::offset_t report_offset,
    output pfd_calib_ctrl_pkg::vote_t report_vote,
    output pfd_calib_data_pkg::hist_cnt_t report_center,
    output pfd_calib_data_pkg::hist_cnt_t report_side
);

    //////////////////////////////////////////////////
    // internal nets
    //////////////////////////////////////////////////

    logic buf_valid;
    pfd_calib_data_pkg::sample_t buf_data;
    logic take;
    logic window_end;
    pfd_calib_data_pkg::sample_t din_avg;
    pfd_calib_data_pkg::hist_cnt_t hist_center;
    pfd_calib_data_pkg::hist_cnt_t hist_side;
    pfd_calib_ctrl_pkg::vote_t hist_comp_out;

    //////////////////////////////////////////////////
    // instances
    //////////////////////////////////////////////////

    calib_sample_buffer u_buf (
        .clk(clk), .rstb(rstb),
        .sample_valid(sample_valid), .sample_data(sample_data), .take(take),
        .sample_credit(sample_credit), .buf_valid(buf_valid), .buf_data(buf_data)
    );

    // both parallel blocks see the same take and window_end
    calib_avg_track #(.Nadc(`PFD_CALIB_NADC), .win_log2(`PFD_CALIB_WIN_LOG2)) u_avg (
        .clk(clk), .rstb(rstb),
        .take(take), .window_end(window_end), .din(buf_data),
        .din_avg(din_avg)
    );

    calib_hist_measure #(.Nadc(`PFD_CALIB_NADC), .Nrange(`PFD_CALIB_NRANGE)) u_hist (
        .clk(clk), .rstb(rstb),
        .take(take), .update(window_end), .din(buf_data), .din_avg(din_avg),
        .Nbin(nbin), .DZ(dz),
        .hist_center(hist_center), .hist_side(hist_side), .hist_comp_out(hist_comp_out)
    );

    pfd_offset_est u_est (
        .clk(clk), .rstb(rstb),
        .buf_valid(buf_valid), .report_credit(report_credit),
        .hist_comp_out(hist_comp_out), .hist_center(hist_center), .hist_side(hist_side),
        .take(take), .window_end(window_end),
        .report_valid(report_valid), .report_offset(report_offset),
        .report_vote(report_vote), .report_center(report_center), .report_side(report_side)
    );

endmodule

`default_nettype wire

//--- pfd_calib_assert.sv
// protocol and reset checks for the calibration top level, attached to it with bind
`timescale 1ns/100ps
`default_nettype none

`include "pfd_calib_settings.svh"

module pfd_calib_assert (
    input wire logic clk,
    input wire logic rstb,
    input wire logic sample_credit,
    input wire logic report_valid,
    input wire logic report_credit,
    input wire pfd_calib_data_pkg::offset_t report_offset,
    input wire pfd_calib_ctrl_pkg::vote_t report_vote
);

    // failures so far, read by the testbench at the end of the run
    int unsigned fail_count = 0;

    //////////////////////////////////////////////////
    // link side bookkeeping
    //////////////////////////////////////////////////

    // credits still held by the estimator
    int credits;
    // offset carried by the previous report
    pfd_calib_data_pkg::offset_t last_offset;
    int offset_step;

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            credits <= `PFD_CALIB_REPORT_CREDITS;
            last_offset <= '0;
        end else begin
            credits <= credits - int'(report_valid) + int'(report_credit);
            if (report_valid) begin
                last_offset <= report_offset;
            end
        end
    end

    always_comb begin
        offset_step = int'(report_offset) - int'(last_offset);
    end

    //////////////////////////////////////////////////
    // properties
    //////////////////////////////////////////////////

    // outputs settle one edge into reset
    reset_quiet: assert property (@(posedge clk) !rstb |=> (!report_valid && !sample_credit))
        else begin
            fail_count++;
            $error("report_valid or sample_credit high while in reset");
        end

    report_has_credit: assert property (@(posedge clk) disable iff (!rstb)
        report_valid |-> (credits > 0))
        else begin
            fail_count++;
            $error("report issued with no report credit outstanding");
        end

    // estimate moves by one vote at most
    offset_small_step: assert property (@(posedge clk) disable iff (!rstb)
        report_valid |-> ((offset_step >= -1) && (offset_step <= 1)))
        else begin
            fail_count++;
            $error("report_offset moved by %0d between reports", offset_step);
        end

    vote_code_used: assert property (@(posedge clk) disable iff (!rstb)
        report_vote != pfd_calib_ctrl_pkg::VOTE_UNUSED)
        else begin
            fail_count++;
            $error("report_vote holds the unused code");
        end

endmodule

`default_nettype wire

//--- pfd_calib_tb.sv
// testbench for the PFD offset calibration core, credit-driven stimulus and sample-order model
`timescale 1ns/100ps
`default_nettype none

`include "pfd_calib_settings.svh"

module pfd_calib_tb;

    localparam int WIN_LOG2 = `PFD_CALIB_WIN_LOG2;
    localparam int WIN = 2**WIN_LOG2;
    localparam int OFF_MAX = `PFD_CALIB_OFFSET_MAX;
    localparam int REP_CREDITS = `PFD_CALIB_REPORT_CREDITS;
    // window shapes
    localparam int SHAPE_FAR = 0;
    localparam int SHAPE_NEAR = 1;
    localparam int SHAPE_SIDE = 2;
    localparam int SHAPE_EVEN = 3;
    // windows per test
    localparam int FAR_WINDOWS = 4;
    localparam int NEAR_WINDOWS = 4;
    localparam int SIDE_WINDOWS = 4;
    localparam int EVEN_WINDOWS = 3;
    localparam int SAT_WINDOWS = 30;
    localparam int STALL_WINDOWS = 4;
    localparam int STALL_CYCLES = 200;
    localparam int TOTAL_SAMPLES = WIN * (FAR_WINDOWS + NEAR_WINDOWS + SIDE_WINDOWS
        + EVEN_WINDOWS + SAT_WINDOWS + STALL_WINDOWS);
    localparam int WATCHDOG_CYCLES = 10 * TOTAL_SAMPLES + 2 * STALL_CYCLES;

    logic clk;
    logic rstb;
    logic sample_valid;
    pfd_calib_data_pkg::sample_t sample_data;
    pfd_calib_ctrl_pkg::cfg_range_t nbin;
    pfd_calib_ctrl_pkg::cfg_range_t dz;
    logic report_credit;
    logic sample_credit;
    logic report_valid;
    pfd_calib_data_pkg::offset_t report_offset;
    pfd_calib_ctrl_pkg::vote_t report_vote;
    pfd_calib_data_pkg::hist_cnt_t report_center;
    pfd_calib_data_pkg::hist_cnt_t report_side;

    pfd_calib_top dut0 (
        .clk(clk), .rstb(rstb),
        .sample_valid(sample_valid), .sample_data(sample_data),
        .nbin(nbin), .dz(dz), .report_credit(report_credit),
        .sample_credit(sample_credit), .report_valid(report_valid),
        .report_offset(report_offset), .report_vote(report_vote),
        .report_center(report_center), .report_side(report_side)
    );

    bind pfd_calib_top pfd_calib_assert u_assert (
        .clk(clk), .rstb(rstb), .sample_credit(sample_credit),
        .report_valid(report_valid), .report_credit(report_credit),
        .report_offset(report_offset), .report_vote(report_vote)
    );

    always #4 clk = ~clk;

    //////////////////////////////////////////////////
    // reference model, runs in sample order
    //////////////////////////////////////////////////

    int seed = 32'h96b0_9820;
    string test_name = "reset";
    int model_avg = 0;
    int model_acc = 0;
    int model_pos = 0;
    int model_left = 0;
    int model_center = 0;
    int model_right = 0;
    int model_offset = 0;
    pfd_calib_data_pkg::sample_t stim_q[$];
    int exp_offset_q[$];
    int exp_vote_q[$];
    int exp_center_q[$];
    int exp_side_q[$];

    function automatic int clip(input int s);
        if (s > 127) begin
            return 127;
        end
        return (s < -128) ? -128 : s;
    endfunction

    // queue a sample for the sender and step the model
    task automatic add_sample(input int s);
        int d;
        int inner;
        int outer;
        int side;
        int diff;
        int vote;
        bit in_l;
        bit in_c;
        bit in_r;
        stim_q.push_back(pfd_calib_data_pkg::sample_t'(s));
        // bins around the previous window's average
        d = s - model_avg;
        inner = int'(nbin) + 1;
        outer = 3 * int'(nbin) + 2;
        in_l = (d > -outer) && (d <= -inner);
        in_c = (d > -inner) && (d < inner);
        in_r = (d >= inner) && (d < outer);
        if (model_pos == WIN - 1) begin
            side = (model_left + model_right) / 2;
            diff = model_center - side;
            if ((model_center == 0) && (side == 0)) begin
                vote = 1;
            end else if (diff > (1 << dz)) begin
                vote = -1;
            end else if (diff < -(1 << dz)) begin
                vote = 1;
            end else begin
                vote = 0;
            end
            model_offset = model_offset + vote;
            if (model_offset > OFF_MAX) begin
                model_offset = OFF_MAX;
            end else if (model_offset < -OFF_MAX) begin
                model_offset = -OFF_MAX;
            end
            exp_offset_q.push_back(model_offset);
            exp_vote_q.push_back(vote);
            exp_center_q.push_back(model_center);
            exp_side_q.push_back(side);
            // counts restart with the closing sample
            model_left = in_l;
            model_center = in_c;
            model_right = in_r;
            model_avg = (model_acc + s) >>> WIN_LOG2;
            model_acc = 0;
            model_pos = 0;
        end else begin
            model_left += in_l;
            model_center += in_c;
            model_right += in_r;
            model_acc += s;
            model_pos++;
        end
    endtask

    // one window shaped around the average the DUT bins against
    task automatic build_window(input int shape);
        int r;
        int sgn;
        int width;
        int s;
        width = 2 * int'(nbin) + 1;
        for (int i = 0; i < WIN; i++) begin
            r = $unsigned($random(seed)) % 16;
            sgn = ($random(seed) & 1) ? 1 : -1;
            case (shape)
                SHAPE_FAR: s = model_avg + sgn * (20 + r);
                SHAPE_NEAR: s = model_avg + (r % width) - int'(nbin);
                // one in eight on the average, rest in the sides
                SHAPE_SIDE: s = (i % 8 == 0) ? model_avg
                    : model_avg + sgn * (int'(nbin) + 1 + r % width);
                // a third center, so center and side mean match
                default: s = (i % 3 == 0) ? model_avg + (r % width) - int'(nbin)
                    : model_avg + sgn * (int'(nbin) + 1 + r % width);
            endcase
            add_sample(clip(s));
        end
    endtask

    //////////////////////////////////////////////////
    // sender, honors sample credits
    //////////////////////////////////////////////////

    int send_credits = `PFD_CALIB_BUF_DEPTH;

    always @(posedge clk) begin
        if (!rstb) begin
            sample_valid <= 1'b0;
        end else begin
            if (sample_credit) begin
                send_credits = send_credits + 1;
            end
            if ((stim_q.size() != 0) && (send_credits > 0)) begin
                sample_valid <= 1'b1;
                sample_data <= stim_q.pop_front();
                send_credits = send_credits - 1;
            end else begin
                sample_valid <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////
    // receiver, checks reports and returns credits
    //////////////////////////////////////////////////

    int owed = 0;
    int credit_delay = 0;
    int report_count = 0;
    bit hold_credits = 1'b0;

    task automatic report_mismatch(input string field, input int expected, input int actual);
        $display("[ERROR] %s %s: expected %0d actual %0d", test_name, field, expected, actual);
        $display("Simulation FAILED");
        $fatal(1, "report field mismatch");
    endtask

    task automatic check_report();
        int e_off;
        int e_vote;
        int e_center;
        int e_side;
        if (exp_offset_q.size() == 0) begin
            $display("%s: a report arrived that the model did not expect", test_name);
            $display("Simulation FAILED");
            $fatal(1, "unexpected report");
        end
        e_off = exp_offset_q.pop_front();
        e_vote = exp_vote_q.pop_front();
        e_center = exp_center_q.pop_front();
        e_side = exp_side_q.pop_front();
        assert (int'(report_offset) == e_off)
            else report_mismatch("offset", e_off, int'(report_offset));
        assert (int'(report_vote) == e_vote)
            else report_mismatch("vote", e_vote, int'(report_vote));
        assert (int'(report_center) == e_center)
            else report_mismatch("center", e_center, int'(report_center));
        assert (int'(report_side) == e_side)
            else report_mismatch("side", e_side, int'(report_side));
        report_count++;
    endtask

    always @(posedge clk) begin
        if (!rstb) begin
            report_credit <= 1'b0;
        end else begin
            report_credit <= 1'b0;
            if (report_valid) begin
                check_report();
                owed = owed + 1;
            end
            // random return delay gives some back-pressure
            if (!hold_credits && (owed > 0)) begin
                if (credit_delay == 0) begin
                    report_credit <= 1'b1;
                    owed = owed - 1;
                    credit_delay = $unsigned($random(seed)) % 6;
                end else begin
                    credit_delay = credit_delay - 1;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////

    // all samples taken, reports checked, credits home
    task automatic drain();
        @(negedge clk);
        while ((stim_q.size() != 0) || (exp_offset_q.size() != 0) || (owed != 0)) begin
            @(negedge clk);
        end
    endtask

    task automatic run_windows(input string name, input int shape, input int count);
        test_name = name;
        for (int w = 0; w < count; w++) begin
            build_window(shape);
        end
        drain();
    endtask

    initial begin
        int stall_start;
        clk = 1'b0;
        rstb = 1'b0;
        sample_valid = 1'b0;
        sample_data = '0;
        nbin = 4'd2;
        dz = 4'd2;
        report_credit = 1'b0;
        repeat (10) @(posedge clk);
        rstb <= 1'b1;
        @(negedge clk);

        run_windows("far_empty", SHAPE_FAR, FAR_WINDOWS);
        run_windows("center_heavy", SHAPE_NEAR, NEAR_WINDOWS);
        run_windows("side_heavy", SHAPE_SIDE, SIDE_WINDOWS);
        run_windows("dead_zone", SHAPE_EVEN, EVEN_WINDOWS);
        run_windows("saturate", SHAPE_FAR, SAT_WINDOWS);

        // withhold report credits until the link stalls
        test_name = "back_pressure";
        hold_credits = 1'b1;
        stall_start = report_count;
        for (int w = 0; w < STALL_WINDOWS; w++) begin
            build_window(SHAPE_FAR);
        end
        while (report_count < stall_start + REP_CREDITS) begin
            @(negedge clk);
        end
        repeat (STALL_CYCLES) @(negedge clk);
        assert (report_count == stall_start + REP_CREDITS)
            else report_mismatch("reports while stalled", stall_start + REP_CREDITS,
                report_count);
        assert (send_credits == 0)
            else report_mismatch("sender credits", 0, send_credits);
        hold_credits = 1'b0;
        drain();

        if (dut0.u_assert.fail_count != 0) begin
            $display("bound assertions failed %0d times", dut0.u_assert.fail_count);
            $display("Simulation FAILED");
            $fatal(1, "bound assertion failure");
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

    // ten cycles per sample plus the stall windows
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired before all reports came back");
        $display("Simulation FAILED");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

//--- pfd_calib.f
+incdir+.
pfd_calib_data_pkg.sv
pfd_calib_ctrl_pkg.sv
calib_sample_buffer.sv
calib_avg_track.sv
calib_hist_measure.sv
pfd_offset_est.sv
pfd_calib_top.sv
pfd_calib_assert.sv
pfd_calib_tb.sv

//--- Makefile
.PHONY: all run lint clean

all: run

obj_dir/Vpfd_calib_tb: pfd_calib.f $(wildcard *.sv) $(wildcard *.svh)
	verilator --binary --timing --assert -Wno-fatal --top-module pfd_calib_tb -f pfd_calib.f

run: obj_dir/Vpfd_calib_tb
	-./obj_dir/Vpfd_calib_tb 2>&1 | tee sim.log
	@if grep -q "Simulation FAILED" sim.log; then echo "run failed"; exit 1; fi
	@if ! grep -q "Simulation PASSED" sim.log; then echo "run ended without a result"; exit 1; fi

lint:
	verilator --lint-only --timing -Wall --top-module pfd_calib_top -f pfd_calib.f

clean:
	rm -rf obj_dir sim.log
